// File: source/pkt_filter_pkg.sv
/* Packet filter shared definitions
   Widths, datapath types, APB register map and core count */
`default_nettype none

package pkt_filter_pkg;

    localparam int NUM_CORES = 4;   // Parallel filter cores
    localparam int WORD_W    = 32;  // Stream word width
    localparam int MAX_BEATS = 16;  // Longest packet in words

    typedef logic [WORD_W-1:0]    word_t;
    typedef logic [3:0]           beat_addr_t;  // Word index inside a buffer
    typedef logic [4:0]           beat_cnt_t;   // Packet length, 1 to 16
    typedef logic [1:0]           core_idx_t;
    typedef logic [NUM_CORES-1:0] core_vec_t;   // One bit per core
    typedef logic [15:0]          count_t;      // Wrapping event counter
    typedef logic [7:0]           apb_addr_t;

    // APB register map, byte offsets
    localparam apb_addr_t REG_CTRL     = 8'h00;  // Bit 0 enable
    localparam apb_addr_t REG_OFFSET   = 8'h04;  // Rule word index
    localparam apb_addr_t REG_MASK     = 8'h08;
    localparam apb_addr_t REG_VALUE    = 8'h0C;
    localparam apb_addr_t REG_DROPPED  = 8'h10;  // Read only
    localparam apb_addr_t REG_REJECTED = 8'h14;  // Read only

    // Buffer occupancy of one filter core
    typedef enum logic [1:0] {FREE, FILLING, ACCEPTED, REJECTED} core_state_t;

    // Forwarder sequencing
    typedef enum logic [1:0] {WAIT_VERDICT, READ, PRESENT} fwd_state_t;

endpackage

`default_nettype wire

// File: source/fill_bus_if.sv
/* Fill bus from the snooper to the filter cores */
`timescale 1ns/1ps
`default_nettype none

interface fill_bus_if;
    logic                       wr_en;      // Write strobe, one word
    pkt_filter_pkg::core_idx_t  wr_sel;     // Target core
    pkt_filter_pkg::beat_addr_t wr_addr;
    pkt_filter_pkg::word_t      wr_data;
    logic                       pkt_end;    // With the last written word
    logic                       pkt_abort;  // Oversize packet, free the core
    pkt_filter_pkg::core_vec_t  core_free;  // Per core, buffer empty

    modport snooper(output wr_en, wr_sel, wr_addr, wr_data, pkt_end, pkt_abort,
                    input core_free);
    modport core(input wr_en, wr_sel, wr_addr, wr_data, pkt_end, pkt_abort,
                 output core_free);
endinterface

`default_nettype wire

// File: source/drain_bus_if.sv
/* Drain bus between the filter cores and the forwarder
   Verdicts and lengths per core, shared read address, per core read data */
`timescale 1ns/1ps
`default_nettype none

interface drain_bus_if;
    pkt_filter_pkg::beat_addr_t rd_addr;        // Same address to every core
    pkt_filter_pkg::core_vec_t  release_sel;    // One-hot release pulse
    pkt_filter_pkg::core_vec_t  verdict_valid;
    pkt_filter_pkg::core_vec_t  accept;         // Meaningful with verdict_valid

    // Per core length and registered read word
    pkt_filter_pkg::beat_cnt_t  pkt_len [pkt_filter_pkg::NUM_CORES];
    pkt_filter_pkg::word_t      rd_data [pkt_filter_pkg::NUM_CORES];

    modport forwarder(output rd_addr, release_sel,
                      input verdict_valid, accept, pkt_len, rd_data);
    modport core(input rd_addr, release_sel,
                 output verdict_valid, accept, pkt_len, rd_data);
endinterface

`default_nettype wire

// File: source/filter_regs.sv
/* APB register block: enable bit, header-match rule,
   dropped and rejected packet counters */
`timescale 1ns/1ps
`default_nettype none

module filter_regs (
    input  logic                       clk,
    input  logic                       reset,
    input  pkt_filter_pkg::apb_addr_t  paddr,
    input  logic                       psel,
    input  logic                       penable,
    input  logic                       pwrite,
    input  pkt_filter_pkg::word_t      pwdata,
    output pkt_filter_pkg::word_t      prdata,
    output logic                       pready,
    output logic                       pslverr,
    input  logic                       dropped_inc,
    input  logic                       rejected_inc,
    output logic                       enable,
    output pkt_filter_pkg::beat_addr_t rule_offset,
    output pkt_filter_pkg::word_t      rule_mask,
    output pkt_filter_pkg::word_t      rule_value
);
    pkt_filter_pkg::count_t dropped_cnt;
    pkt_filter_pkg::count_t rejected_cnt;
    logic                   access;    // APB access phase
    logic                   addr_hit;

    assign access  = psel && penable;
    assign pready  = 1'b1;                  // Zero wait states
    assign pslverr = access && !addr_hit;

    // Read mux, also flags mapped addresses
    always_comb begin
        addr_hit = 1'b1;
        case (paddr)
            pkt_filter_pkg::REG_CTRL:     prdata = pkt_filter_pkg::word_t'(enable);
            pkt_filter_pkg::REG_OFFSET:   prdata = pkt_filter_pkg::word_t'(rule_offset);
            pkt_filter_pkg::REG_MASK:     prdata = rule_mask;
            pkt_filter_pkg::REG_VALUE:    prdata = rule_value;
            pkt_filter_pkg::REG_DROPPED:  prdata = pkt_filter_pkg::word_t'(dropped_cnt);
            pkt_filter_pkg::REG_REJECTED: prdata = pkt_filter_pkg::word_t'(rejected_cnt);
            default: begin
                prdata   = '0;
                addr_hit = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            enable       <= 1'b0;   // Datapath held until software enables it
            rule_offset  <= '0;
            rule_mask    <= '0;
            rule_value   <= '0;
            dropped_cnt  <= '0;
            rejected_cnt <= '0;
        end else begin
            if (access && pwrite) begin
                case (paddr)
                    pkt_filter_pkg::REG_CTRL:   enable      <= pwdata[0];
                    pkt_filter_pkg::REG_OFFSET: rule_offset <= pwdata[3:0];
                    pkt_filter_pkg::REG_MASK:   rule_mask   <= pwdata;
                    pkt_filter_pkg::REG_VALUE:  rule_value  <= pwdata;
                    default: ;                  // Counters are read only
                endcase
            end
            // Counters wrap
            dropped_cnt  <= dropped_cnt + pkt_filter_pkg::count_t'(dropped_inc);
            rejected_cnt <= rejected_cnt + pkt_filter_pkg::count_t'(rejected_inc);
        end
    end
endmodule

`default_nettype wire

// File: source/stream_snooper.sv
/* Input stream snooper: writes each packet into the next core in
   round-robin order, drops packets for a busy core or oversize ones */
`timescale 1ns/1ps
`default_nettype none

module stream_snooper (
    input  logic                  clk,
    input  logic                  reset,
    input  pkt_filter_pkg::word_t in_data,
    input  logic                  in_valid,
    input  logic                  in_last,
    output logic                  in_ready,
    fill_bus_if.snooper           fill,
    output logic                  dropped_inc
);
    pkt_filter_pkg::core_idx_t target;    // Round-robin pointer
    pkt_filter_pkg::beat_cnt_t beat;      // Words written so far
    logic                      in_pkt;    // Inside a packet
    logic                      keep;      // Current packet goes to target
    logic                      take, keep_now, overflow, write;

    assign in_ready = !reset;             // No back-pressure out of reset
    assign take     = in_valid && in_ready;

    // Keep or drop is decided once, on the first word
    assign keep_now = in_pkt ? keep : fill.core_free[target];
    assign overflow = keep_now && (beat == pkt_filter_pkg::MAX_BEATS);  // 17th word
    assign write    = keep_now && !overflow;

    assign fill.wr_en     = take && write;
    assign fill.wr_sel    = target;
    assign fill.wr_addr   = beat[3:0];
    assign fill.wr_data   = in_data;
    assign fill.pkt_end   = take && write && in_last;
    assign fill.pkt_abort = take && overflow;   // Core goes back to FREE
    assign dropped_inc    = take && in_last && (!keep_now || overflow);

    always_ff @(posedge clk) begin
        if (reset) begin
            target <= '0;
            beat   <= '0;
            in_pkt <= 1'b0;
            keep   <= 1'b0;
        end else if (take) begin
            in_pkt <= !in_last;
            keep   <= write && !in_last;   // Cleared by an abort
            if (in_last)
                beat <= '0;
            else if (write)
                beat <= beat + pkt_filter_pkg::beat_cnt_t'(1);
            // Only a completed packet moves the pointer, the forwarder waits there
            if (write && in_last)
                target <= target + pkt_filter_pkg::core_idx_t'(1);
        end
    end
endmodule

`default_nettype wire

// File: source/filter_core.sv
/* Filter core: one 16-word packet buffer with the header-match rule
   and the accept or reject verdict */
`timescale 1ns/1ps
`default_nettype none

module filter_core (
    input  logic                       clk,
    input  logic                       reset,
    input  pkt_filter_pkg::core_idx_t  core_id,
    fill_bus_if.core                   fill,
    drain_bus_if.core                  drain,
    input  pkt_filter_pkg::beat_addr_t rule_offset,
    input  pkt_filter_pkg::word_t      rule_mask,
    input  pkt_filter_pkg::word_t      rule_value
);
    pkt_filter_pkg::word_t       buffer [pkt_filter_pkg::MAX_BEATS];
    pkt_filter_pkg::word_t       rd_q;       // Registered read port
    pkt_filter_pkg::word_t       rule_word;  // Captured header word
    pkt_filter_pkg::beat_cnt_t   len;
    pkt_filter_pkg::core_state_t state;
    logic                        rule_seen;  // Packet reached the rule offset
    logic                        sel, wr, at_offset, hit;

    assign sel       = fill.wr_sel == core_id;
    assign wr        = fill.wr_en && sel;
    assign at_offset = fill.wr_addr == rule_offset;

    // Rule word may arrive with the last write
    assign hit = at_offset ? ((fill.wr_data & rule_mask) == rule_value)
               : (state == pkt_filter_pkg::FILLING) && rule_seen
                 && ((rule_word & rule_mask) == rule_value);

    assign fill.core_free[core_id]     = state == pkt_filter_pkg::FREE;
    assign drain.verdict_valid[core_id] = (state == pkt_filter_pkg::ACCEPTED)
                                        || (state == pkt_filter_pkg::REJECTED);
    assign drain.accept[core_id]       = state == pkt_filter_pkg::ACCEPTED;
    assign drain.pkt_len[core_id]      = len;
    assign drain.rd_data[core_id]      = rd_q;

    // Buffer and payload
    always_ff @(posedge clk) begin
        if (wr) begin
            buffer[fill.wr_addr] <= fill.wr_data;
            len <= pkt_filter_pkg::beat_cnt_t'(fill.wr_addr) + pkt_filter_pkg::beat_cnt_t'(1);
            if (at_offset)
                rule_word <= fill.wr_data;
        end
        rd_q <= buffer[drain.rd_addr];  // One cycle read latency
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= pkt_filter_pkg::FREE;
            rule_seen <= 1'b0;
        end else begin
            if (wr)   // First write restarts the flag
                rule_seen <= at_offset || ((state == pkt_filter_pkg::FILLING) && rule_seen);
            case (state)
                pkt_filter_pkg::FREE, pkt_filter_pkg::FILLING: begin
                    if (fill.pkt_abort && sel)
                        state <= pkt_filter_pkg::FREE;
                    else if (wr && fill.pkt_end)
                        state <= hit ? pkt_filter_pkg::ACCEPTED : pkt_filter_pkg::REJECTED;
                    else if (wr)
                        state <= pkt_filter_pkg::FILLING;
                end
                default: if (drain.release_sel[core_id]) state <= pkt_filter_pkg::FREE;
            endcase
        end
    end
endmodule

`default_nettype wire

// File: source/stream_forwarder.sv
/* Output forwarder: visits the cores in round-robin order, streams
   accepted packets and releases rejected ones */
`timescale 1ns/1ps
`default_nettype none

module stream_forwarder (
    input  logic                  clk,
    input  logic                  reset,
    drain_bus_if.forwarder        drain,
    output pkt_filter_pkg::word_t out_data,
    output logic                  out_valid,
    output logic                  out_last,
    input  logic                  out_ready,
    output logic                  rejected_inc
);
    pkt_filter_pkg::fwd_state_t state;
    pkt_filter_pkg::core_idx_t  ptr;      // Core being drained
    pkt_filter_pkg::beat_addr_t beat;     // Word being read or presented
    pkt_filter_pkg::core_vec_t  ptr_hot;
    logic                       handshake, last_word;

    assign ptr_hot       = pkt_filter_pkg::core_vec_t'(1) << ptr;
    assign drain.rd_addr = beat;

    // Core read register holds the word while beat is unchanged
    assign out_data  = drain.rd_data[ptr];
    assign out_valid = state == pkt_filter_pkg::PRESENT;
    assign last_word = (pkt_filter_pkg::beat_cnt_t'(beat) + pkt_filter_pkg::beat_cnt_t'(1))
                       == drain.pkt_len[ptr];
    assign out_last  = last_word;
    assign handshake = out_valid && out_ready;

    assign rejected_inc = (state == pkt_filter_pkg::WAIT_VERDICT)
                          && drain.verdict_valid[ptr] && !drain.accept[ptr];
    // Free the core on a reject or after its last word
    assign drain.release_sel = (rejected_inc || (handshake && last_word)) ? ptr_hot : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= pkt_filter_pkg::WAIT_VERDICT;
            ptr   <= '0;
            beat  <= '0;
        end else begin
            case (state)
                pkt_filter_pkg::WAIT_VERDICT: if (drain.verdict_valid[ptr]) begin
                    if (drain.accept[ptr])
                        state <= pkt_filter_pkg::READ;
                    else
                        ptr <= ptr + pkt_filter_pkg::core_idx_t'(1);   // Skip rejected
                end
                pkt_filter_pkg::READ: state <= pkt_filter_pkg::PRESENT;  // Read in flight
                pkt_filter_pkg::PRESENT: if (handshake) begin
                    if (last_word) begin
                        ptr   <= ptr + pkt_filter_pkg::core_idx_t'(1);
                        beat  <= '0;
                        state <= pkt_filter_pkg::WAIT_VERDICT;
                    end else begin
                        beat  <= beat + pkt_filter_pkg::beat_addr_t'(1);
                        state <= pkt_filter_pkg::READ;
                    end
                end
                default: state <= pkt_filter_pkg::WAIT_VERDICT;
            endcase
        end
    end
endmodule

`default_nettype wire

// File: source/pkt_filter_top.sv
/* Stream packet filter top: APB registers, snooper, parallel
   filter cores and the in-order forwarder */
`timescale 1ns/1ps
`default_nettype none

module pkt_filter_top (
    input  logic                      clk,
    input  logic                      reset,
    input  pkt_filter_pkg::apb_addr_t paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  pkt_filter_pkg::word_t     pwdata,
    output pkt_filter_pkg::word_t     prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  pkt_filter_pkg::word_t     in_data,
    input  logic                      in_valid,
    input  logic                      in_last,
    output logic                      in_ready,
    output pkt_filter_pkg::word_t     out_data,
    output logic                      out_valid,
    output logic                      out_last,
    input  logic                      out_ready
);
    logic                       enable;
    logic                       dp_reset;       // Datapath reset
    logic                       dropped_inc, rejected_inc;
    pkt_filter_pkg::beat_addr_t rule_offset;
    pkt_filter_pkg::word_t      rule_mask, rule_value;

    // Datapath stays in reset while disabled
    assign dp_reset = reset || !enable;

    fill_bus_if  fill ();
    drain_bus_if drain ();

    filter_regs i_regs (.clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata, .prdata,
                        .pready, .pslverr, .dropped_inc, .rejected_inc, .enable,
                        .rule_offset, .rule_mask, .rule_value);

    stream_snooper i_snooper (.clk, .reset(dp_reset), .in_data, .in_valid, .in_last,
                              .in_ready, .fill(fill.snooper), .dropped_inc);

    for (genvar i = 0; i < pkt_filter_pkg::NUM_CORES; i++) begin : g_core
        filter_core i_core (.clk, .reset(dp_reset),
                            .core_id(pkt_filter_pkg::core_idx_t'(i)),  // Fixed per slot
                            .fill(fill.core), .drain(drain.core),
                            .rule_offset, .rule_mask, .rule_value);
    end

    stream_forwarder i_forwarder (.clk, .reset(dp_reset), .drain(drain.forwarder),
                                  .out_data, .out_valid, .out_last, .out_ready,
                                  .rejected_inc);
endmodule

`default_nettype wire

// File: tests/pkt_filter_asserts.sv
/* Protocol assertions for the packet filter top, APB and both streams */
`timescale 1ns/1ps
`default_nettype none

module pkt_filter_asserts (
    input logic                  clk,
    input logic                  reset,
    input logic                  psel,
    input logic                  penable,
    input logic                  pready,
    input logic                  enable,
    input logic                  in_ready,
    input logic                  out_valid,
    input logic                  out_ready,
    input logic                  out_last,
    input pkt_filter_pkg::word_t out_data
);
    int error_count = 0;    // Failed assertions so far

    // Stalled output word holds
    a_out_hold: assert property (@(posedge clk) disable iff (reset || !enable)
        out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
        else begin
            error_count++;
            $error("output word changed while stalled");
        end

    a_apb_ready: assert property (@(posedge clk) psel && penable |-> pready)
        else begin
            error_count++;
            $error("pready low in the APB access phase");
        end

    a_in_block: assert property (@(posedge clk) !enable |-> !in_ready)
        else begin
            error_count++;
            $error("in_ready high while disabled");
        end

    a_reset_quiet: assert property (@(posedge clk) reset |=> !out_valid)
        else begin
            error_count++;
            $error("out_valid high right after reset");
        end
endmodule

bind pkt_filter_top pkt_filter_asserts i_asserts (.clk, .reset, .psel, .penable, .pready,
    .enable, .in_ready, .out_valid, .out_ready, .out_last, .out_data);

`default_nettype wire

// File: tests/pkt_filter_tb.sv
/* Packet filter testbench: APB and stream drivers, rule reference model,
   output scoreboard and watchdog */
`timescale 1ns/1ps
`default_nettype none

module pkt_filter_tb;
    logic clk = 1'b0;
    logic reset, psel, penable, pwrite, pready, pslverr;
    logic in_valid, in_last, in_ready, out_valid, out_last, out_ready;
    pkt_filter_pkg::apb_addr_t  paddr;
    pkt_filter_pkg::word_t      pwdata, prdata, in_data, out_data;
    pkt_filter_pkg::word_t      rd_word;                // Last APB read
    logic                       rd_err;
    pkt_filter_pkg::word_t      pkt_buf [17];           // Packet being sent
    pkt_filter_pkg::word_t      exp_data [$];           // Expected output words
    logic                       exp_last [$];
    pkt_filter_pkg::count_t     exp_dropped = '0;
    pkt_filter_pkg::count_t     exp_rejected = '0;
    pkt_filter_pkg::beat_addr_t r_off;                  // Rule copy for the model
    pkt_filter_pkg::word_t      r_mask, r_value;
    logic [31:0] rng = 32'd15481;
    logic [31:0] rng_ready;
    logic        hold_ready = 1'b0;
    int          pending = 0;                           // Accepted packets not yet out
    int          test2_pkts = 20;
    int          test3_pkts = 12;

    pkt_filter_top i_dut (.*);

    always #50 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    // Header word must exist and match under the mask
    function automatic bit ref_accept(input int len);
        return (len > int'(r_off)) && ((pkt_buf[r_off] & r_mask) == r_value);
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_word(input string name, input pkt_filter_pkg::word_t got, exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s = %h, expected %h", $time, name, got, exp));
    endtask

    task automatic check_count(input string name, input pkt_filter_pkg::count_t got, exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, exp);
        if (got !== exp)
            abort_run($sformatf("Fail at %0t: %s = %b, expected %b", $time, name, got, exp));
    endtask

    task automatic apb_access(input pkt_filter_pkg::apb_addr_t addr, input logic write,
                              input pkt_filter_pkg::word_t data);
        @(posedge clk);
        paddr   <= addr;
        pwrite  <= write;
        pwdata  <= data;
        psel    <= 1'b1;
        @(posedge clk);
        penable <= 1'b1;     // Access phase
        @(negedge clk);
        rd_word = prdata;
        rd_err  = pslverr;
        check_bit("pready", pready, 1'b1);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic expect_reg(input pkt_filter_pkg::apb_addr_t addr, input string name,
                              input pkt_filter_pkg::word_t exp);
        apb_access(addr, 1'b0, '0);
        check_bit("pslverr", rd_err, 1'b0);
        check_word(name, rd_word, exp);
    endtask

    task automatic expect_count(input pkt_filter_pkg::apb_addr_t addr, input string name,
                                input pkt_filter_pkg::count_t exp);
        apb_access(addr, 1'b0, '0);
        check_count(name, rd_word[15:0], exp);
    endtask

    task automatic set_rule(input pkt_filter_pkg::beat_addr_t off,
                            input pkt_filter_pkg::word_t mask, value);
        r_off   = off;
        r_mask  = mask;
        r_value = value;
        apb_access(pkt_filter_pkg::REG_OFFSET, 1'b1, pkt_filter_pkg::word_t'(off));
        apb_access(pkt_filter_pkg::REG_MASK, 1'b1, mask);
        apb_access(pkt_filter_pkg::REG_VALUE, 1'b1, value);
    endtask

    // Kind 0 plants a matching rule word, kind 1 flips its lowest masked bit
    task automatic send_packet(input int len, input int kind, input bit kept, input bit counted);
        for (int i = 0; i < len; i++) begin
            rng = xorshift32(rng);
            pkt_buf[i] = rng;
        end
        if (len > int'(r_off))
            pkt_buf[r_off] = (pkt_buf[r_off] & ~r_mask)
                           | (r_value ^ ((kind == 1) ? (r_mask & (~r_mask + 32'h1)) : 32'h0));
        if (kept && ref_accept(len)) begin
            for (int i = 0; i < len; i++) begin
                exp_data.push_back(pkt_buf[i]);
                exp_last.push_back(i == len - 1);
            end
            pending++;
        end else if (kept) begin
            exp_rejected++;
        end else if (counted) begin
            exp_dropped++;
        end
        for (int i = 0; i < len; i++) begin
            @(posedge clk);
            in_data  <= pkt_buf[i];
            in_valid <= 1'b1;
            in_last  <= (i == len - 1);
        end
        @(posedge clk);
        in_valid <= 1'b0;
        in_last  <= 1'b0;
    endtask

    // At most one older accepted packet ahead, then room for released rejects
    task automatic wait_room;
        while (pending > 1)
            @(posedge clk);
        rng = xorshift32(rng);
        repeat (5 + rng[1:0]) @(posedge clk);
    endtask

    task automatic wait_drained;
        while (exp_data.size() != 0)
            @(posedge clk);
        repeat (8) @(posedge clk);   // Late releases and counter updates
    endtask

    always @(posedge clk) begin
        rng_ready = xorshift32(rng_ready);
        out_ready <= !hold_ready && rng_ready[0];
    end

    // Scoreboard; negedge values hold through the handshake edge
    always @(negedge clk) begin
        if (!reset && out_valid && out_ready) begin
            if (exp_data.size() == 0) begin
                abort_run("Output word appeared where no packet was expected");
            end else begin
                check_word("out_data", out_data, exp_data.pop_front());
                check_bit("out_last", out_last, exp_last[0]);
                if (exp_last.pop_front())
                    pending--;
            end
        end
    end

    initial begin
        repeat (10 + 2000 * (test2_pkts + test3_pkts + 9)) @(posedge clk);
        abort_run("Timeout: the tests did not finish in time");
    end

    initial begin
        rng_ready = xorshift32(rng);
        reset     = 1'b1;
        psel      = 1'b0;
        penable   = 1'b0;
        pwrite    = 1'b0;
        paddr     = '0;
        pwdata    = '0;
        in_data   = '0;
        in_valid  = 1'b0;
        in_last   = 1'b0;
        out_ready = 1'b0;
        repeat (10) @(posedge clk);
        reset <= 1'b0;

        // Reset values, rule readback, unmapped address
        expect_reg(pkt_filter_pkg::REG_CTRL, "ctrl", '0);
        expect_reg(pkt_filter_pkg::REG_OFFSET, "rule_offset", '0);
        expect_reg(pkt_filter_pkg::REG_MASK, "rule_mask", '0);
        expect_reg(pkt_filter_pkg::REG_VALUE, "rule_value", '0);
        expect_count(pkt_filter_pkg::REG_DROPPED, "dropped", '0);
        expect_count(pkt_filter_pkg::REG_REJECTED, "rejected", '0);
        set_rule(4'd9, 32'hFF00_00FF, 32'h5A00_00A5);
        expect_reg(pkt_filter_pkg::REG_OFFSET, "rule_offset", 32'h9);
        expect_reg(pkt_filter_pkg::REG_MASK, "rule_mask", 32'hFF00_00FF);
        expect_reg(pkt_filter_pkg::REG_VALUE, "rule_value", 32'h5A00_00A5);
        apb_access(8'h18, 1'b0, '0);
        check_bit("pslverr", rd_err, 1'b1);

        // Matching traffic under random back-pressure
        set_rule(4'd0, 32'hFF00_00FF, 32'h5A00_00A5);
        apb_access(pkt_filter_pkg::REG_CTRL, 1'b1, 32'h1);
        repeat (test2_pkts) begin
            wait_room();
            rng = xorshift32(rng);
            send_packet(1 + rng[3:0], 0, 1'b1, 1'b1);
        end
        wait_drained();
        expect_count(pkt_filter_pkg::REG_REJECTED, "rejected", exp_rejected);

        // Mismatching and short packets between accepted ones
        set_rule(4'd2, 32'hFFFF_0000, 32'hABCD_0000);
        for (int i = 0; i < test3_pkts; i++) begin
            wait_room();
            rng = xorshift32(rng);
            send_packet((i % 3 == 2) ? 1 + rng[0] : 3 + rng[3:0] % 14, i % 3, 1'b1, 1'b1);
        end
        wait_drained();
        expect_count(pkt_filter_pkg::REG_REJECTED, "rejected", exp_rejected);

        // Output stalled: four cores fill, two packets dropped
        hold_ready = 1'b1;
        for (int i = 0; i < 6; i++) begin
            repeat (3) @(posedge clk);
            send_packet(3 + i, 0, (i < 4), 1'b1);
        end
        repeat (4) @(posedge clk);
        expect_count(pkt_filter_pkg::REG_DROPPED, "dropped", exp_dropped);
        hold_ready = 1'b0;
        wait_drained();

        // Oversize packet
        send_packet(17, 0, 1'b0, 1'b1);
        repeat (4) @(posedge clk);
        expect_count(pkt_filter_pkg::REG_DROPPED, "dropped", exp_dropped);

        // Disabled datapath ignores input
        apb_access(pkt_filter_pkg::REG_CTRL, 1'b1, 32'h0);
        @(negedge clk);
        check_bit("in_ready", in_ready, 1'b0);
        send_packet(5, 0, 1'b0, 1'b0);
        repeat (20) @(posedge clk);
        apb_access(pkt_filter_pkg::REG_CTRL, 1'b1, 32'h1);
        send_packet(5, 0, 1'b1, 1'b1);
        wait_drained();
        expect_count(pkt_filter_pkg::REG_DROPPED, "dropped", exp_dropped);
        expect_count(pkt_filter_pkg::REG_REJECTED, "rejected", exp_rejected);

        if (i_dut.i_asserts.error_count != 0) begin
            abort_run("A protocol assertion failed during the run");
        end else begin
            $display("TESTBENCH PASSED");
            $finish;
        end
    end
endmodule

`default_nettype wire

// File: list.f
source/pkt_filter_pkg.sv
source/fill_bus_if.sv
source/drain_bus_if.sv
source/filter_regs.sv
source/stream_snooper.sv
source/filter_core.sv
source/stream_forwarder.sv
source/pkt_filter_top.sv
tests/pkt_filter_asserts.sv
tests/pkt_filter_tb.sv

// File: Makefile
# Verilator build and run of the packet filter testbench
VERILATOR ?= verilator
TOP       ?= pkt_filter_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then echo "Simulation did not pass"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
